/* flist.f */
common/lsu_pkg.sv
design/scratch_ram.sv
design/lsu_instr_ctrl.sv
store/row_store_engine.sv
design/lsu_top.sv
sim/lsu_props.sv
sim/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - common/lsu_pkg.sv
      - design/scratch_ram.sv
      - design/lsu_instr_ctrl.sv
      - store/row_store_engine.sv
      - design/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_props.sv
      - sim/tb_lsu.sv

/* sim/tb_lsu.sv */
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int clk_period = 20;
    localparam int reset_cycles = 8;
    // test sizes that bound the run length
    localparam int total_rows = 29;
    localparam int max_stalls = 24;
    localparam int readback_words = 33;
    localparam int store_count = 6;
    localparam int limit_cycles = 2 * (reset_cycles + total_rows + max_stalls
        + 3 * readback_words + 8 * store_count);

    logic clk;
    logic reset;
    logic instr_vld;
    lsu_op_e instr_op;
    row_idx_t start_x, start_y, elem_cnt, row_cnt;
    ram_addr_t st_addr;
    logic instr_rdy;
    acc_rows_t mxu_rows;
    logic mxu_data_rdy;
    logic iram_rd_en, wram_rd_en;
    ram_addr_t iram_rd_addr, wram_rd_addr;
    row_word_t iram_rd_data, wram_rd_data;

    // accumulator contents as driven, plus shadow buffers
    acc_rows_t acc_image;
    row_word_t iram_model [ram_depth];
    row_word_t wram_model [ram_depth];
    logic [31:0] lcg_state;
    int errors;
    int checks;

    lsu_top #(
        .ROWS      (acc_rows),
        .ROW_BYTES (row_bytes),
        .RAM_DEPTH (ram_depth)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // byte i takes source byte x+i inside the element count and the row
    function automatic row_word_t window(row_word_t src, int x, int elem);
        row_word_t res;
        res = '0;
        for (int i = 0; i < row_bytes; i++) begin
            if (i <= elem && x + i < row_bytes) begin
                res[8*i +: 8] = src[8*(x+i) +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input row_word_t got, input row_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic load_rows();
        @(posedge clk);
        for (int r = 0; r < acc_rows; r++) begin
            for (int w = 0; w < 4; w++) begin
                acc_image[r][32*w +: 32] = lcg_next();
            end
        end
        mxu_rows <= acc_image;
    endtask

    task automatic model_store(input lsu_op_e op, input int x, input int y, input int elem,
                               input int rows, input int addr);
        row_word_t w;
        int a;
        for (int k = 0; k <= rows; k++) begin
            w = window(acc_image[(y + k) % acc_rows], x, elem);
            a = (addr + k) % ram_depth;
            if (op == op_st_iram) begin
                iram_model[a] = w;
            end else begin
                wram_model[a] = w;
            end
        end
    endtask

    // holds the instruction valid until accepted, counts busy cycles
    task automatic issue_store(input lsu_op_e op, input int x, input int y, input int elem,
                               input int rows, input int addr, output int waited);
        @(posedge clk);
        instr_vld <= 1'b1;
        instr_op <= op;
        start_x <= row_idx_t'(x);
        start_y <= row_idx_t'(y);
        elem_cnt <= row_idx_t'(elem);
        row_cnt <= row_idx_t'(rows);
        st_addr <= ram_addr_t'(addr);
        waited = 0;
        @(negedge clk);
        while (!instr_rdy) begin
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        instr_vld <= 1'b0;
        model_store(op, x, y, elem, rows, addr);
    endtask

    // ready may only rise in the cycle of the last write
    task automatic wait_store_done(input int rows, input bit stall);
        int writes;
        int low_run;
        bit finished;
        logic exp_rdy;
        logic [31:0] r;
        writes = 0;
        low_run = 0;
        finished = 0;
        @(negedge clk);
        check_bit("instr_rdy", instr_rdy, 1'b0);
        while (!finished) begin
            @(posedge clk);
            if (stall) begin
                r = lcg_next();
                // at most three idle cycles in a row
                if (low_run < 3 && r[7]) begin
                    mxu_data_rdy <= 1'b0;
                    low_run++;
                end else begin
                    mxu_data_rdy <= 1'b1;
                    low_run = 0;
                end
            end
            @(negedge clk);
            exp_rdy = mxu_data_rdy && (writes == rows);
            check_bit("instr_rdy", instr_rdy, exp_rdy);
            if (mxu_data_rdy) begin
                writes++;
            end
            if (exp_rdy) begin
                finished = 1;
            end else if (writes > rows) begin
                errors++;
                $display("store of %0d rows never reopened the instruction port", rows + 1);
                finished = 1;
            end
        end
        @(posedge clk);
        mxu_data_rdy <= 1'b1;
    endtask

    task automatic read_range(input lsu_op_e op, input int addr, input int count);
        ram_addr_t a;
        for (int k = 0; k < count; k++) begin
            a = ram_addr_t'((addr + k) % ram_depth);
            @(posedge clk);
            iram_rd_en <= (op == op_st_iram);
            wram_rd_en <= (op == op_st_wram);
            iram_rd_addr <= a;
            wram_rd_addr <= a;
            @(posedge clk);
            iram_rd_en <= 1'b0;
            wram_rd_en <= 1'b0;
            @(negedge clk);
            if (op == op_st_iram) begin
                check_word($sformatf("iram_rd_data[%02h]", a), iram_rd_data, iram_model[a]);
            end else begin
                check_word($sformatf("wram_rd_data[%02h]", a), wram_rd_data, wram_model[a]);
            end
        end
    endtask

    task automatic test_full_row();
        int waited;
        load_rows();
        issue_store(op_st_iram, 0, 2, 15, 3, 'h10, waited);
        wait_store_done(3, 0);
        read_range(op_st_iram, 'h10, 4);
    endtask

    task automatic test_window_wrap();
        int waited;
        load_rows();
        issue_store(op_st_wram, 5, 14, 6, 4, 'h10, waited);
        wait_store_done(4, 0);
        read_range(op_st_wram, 'h10, 5);
        // input RAM words from the first store share these addresses
        read_range(op_st_iram, 'h10, 4);
    endtask

    task automatic test_backpressure();
        int waited;
        load_rows();
        issue_store(op_st_iram, 3, 7, 9, 7, 'h80, waited);
        wait_store_done(7, 1);
        read_range(op_st_iram, 'h80, 8);
    endtask

    task automatic test_back_to_back();
        int waited;
        load_rows();
        issue_store(op_st_wram, 0, 1, 3, 2, 'h20, waited);
        issue_store(op_st_iram, 9, 10, 15, 5, 'h30, waited);
        // second one waits out the two cycles before the last write
        if (waited != 2) begin
            errors++;
            $display("second instruction accepted after %0d busy cycles, expected 2", waited);
        end
        wait_store_done(5, 0);
        read_range(op_st_wram, 'h20, 3);
        read_range(op_st_iram, 'h30, 6);
    endtask

    task automatic test_addr_wrap();
        int waited;
        load_rows();
        issue_store(op_st_wram, 2, 4, 11, 2, 254, waited);
        wait_store_done(2, 0);
        read_range(op_st_wram, 254, 3);
    endtask

    initial begin
        lcg_state = 32'he5dc61f8;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        instr_vld = 1'b0;
        instr_op = op_st_iram;
        start_x = '0;
        start_y = '0;
        elem_cnt = '0;
        row_cnt = '0;
        st_addr = '0;
        mxu_rows = '0;
        acc_image = '0;
        mxu_data_rdy = 1'b1;
        iram_rd_en = 1'b0;
        wram_rd_en = 1'b0;
        iram_rd_addr = '0;
        wram_rd_addr = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("instr_rdy", instr_rdy, 1'b1);
        test_full_row();
        test_window_wrap();
        test_backpressure();
        test_back_to_back();
        test_addr_wrap();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles before the tests finished", limit_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sim/lsu_props.sv */
module lsu_props (
    input logic clk,
    input logic reset,
    input logic instr_vld,
    input logic instr_rdy,
    input logic start
);
    timeunit 1ns;
    timeprecision 1ps;

    // start is a single-cycle pulse
    a_start_pulse: assert property (@(posedge clk) disable iff (reset)
        start |=> !start)
        else $error("start high on two consecutive cycles");

    // port open once reset has been seen
    a_rdy_after_reset: assert property (@(posedge clk)
        reset |=> instr_rdy)
        else $error("instr_rdy low in the cycle after reset");

    a_start_follows_accept: assert property (@(posedge clk) disable iff (reset)
        (instr_vld && instr_rdy) |=> start)
        else $error("no start pulse after an accepted instruction");

endmodule

bind lsu_instr_ctrl lsu_props u_props (
    .clk       (clk),
    .reset     (reset),
    .instr_vld (instr_vld),
    .instr_rdy (instr_rdy),
    .start     (start)
);

/* design/lsu_top.sv */
module lsu_top #(
    parameter int ROWS = lsu_pkg::acc_rows,
    parameter int ROW_BYTES = lsu_pkg::row_bytes,
    parameter int RAM_DEPTH = lsu_pkg::ram_depth
) (
    input  logic                 clk,
    input  logic                 reset,

    // instruction port from the decoder
    input  logic                 instr_vld,
    input  lsu_pkg::lsu_op_e     instr_op,
    input  lsu_pkg::row_idx_t    start_x,
    input  lsu_pkg::row_idx_t    start_y,
    input  lsu_pkg::row_idx_t    elem_cnt,
    input  lsu_pkg::row_idx_t    row_cnt,
    input  lsu_pkg::ram_addr_t   st_addr,
    output logic                 instr_rdy,

    // accumulator side
    input  lsu_pkg::acc_rows_t   mxu_rows,
    input  logic                 mxu_data_rdy,

    // feed reads toward the matrix unit
    input  logic                 iram_rd_en,
    input  lsu_pkg::ram_addr_t   iram_rd_addr,
    output lsu_pkg::row_word_t   iram_rd_data,
    input  logic                 wram_rd_en,
    input  lsu_pkg::ram_addr_t   wram_rd_addr,
    output lsu_pkg::row_word_t   wram_rd_data
);
    import lsu_pkg::*;

    // controller to engine
    logic      start;
    logic      done;
    lsu_op_e   op_q;
    row_idx_t  x_q;
    row_idx_t  y_q;
    row_idx_t  elem_q;
    row_idx_t  rows_q;
    ram_addr_t addr_q;

    // engine to buffers, data and address shared
    logic      iram_we;
    logic      wram_we;
    ram_addr_t wr_addr;
    row_word_t wr_data;

    lsu_instr_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .instr_vld (instr_vld),
        .instr_op  (instr_op),
        .start_x   (start_x),
        .start_y   (start_y),
        .elem_cnt  (elem_cnt),
        .row_cnt   (row_cnt),
        .st_addr   (st_addr),
        .done      (done),
        .instr_rdy (instr_rdy),
        .start     (start),
        .op_q      (op_q),
        .x_q       (x_q),
        .y_q       (y_q),
        .elem_q    (elem_q),
        .rows_q    (rows_q),
        .addr_q    (addr_q)
    );

    row_store_engine #(
        .ROWS      (ROWS),
        .ROW_BYTES (ROW_BYTES)
    ) u_store (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .mxu_data_rdy (mxu_data_rdy),
        .mxu_rows     (mxu_rows),
        .op_q         (op_q),
        .x_q          (x_q),
        .y_q          (y_q),
        .elem_q       (elem_q),
        .rows_q       (rows_q),
        .addr_q       (addr_q),
        .done         (done),
        .iram_we      (iram_we),
        .wram_we      (wram_we),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    scratch_ram #(
        .DEPTH (RAM_DEPTH),
        .WIDTH (8 * ROW_BYTES)
    ) u_iram (
        .clk     (clk),
        .we      (iram_we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (iram_rd_en),
        .rd_addr (iram_rd_addr),
        .rd_data (iram_rd_data)
    );

    scratch_ram #(
        .DEPTH (RAM_DEPTH),
        .WIDTH (8 * ROW_BYTES)
    ) u_wram (
        .clk     (clk),
        .we      (wram_we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (wram_rd_en),
        .rd_addr (wram_rd_addr),
        .rd_data (wram_rd_data)
    );

endmodule

/* store/row_store_engine.sv */
module row_store_engine #(
    parameter int ROWS = lsu_pkg::acc_rows,
    parameter int ROW_BYTES = lsu_pkg::row_bytes
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,

    // accumulator side
    input  logic                 mxu_data_rdy,
    input  lsu_pkg::acc_rows_t   mxu_rows,

    // latched instruction
    input  lsu_pkg::lsu_op_e     op_q,
    input  lsu_pkg::row_idx_t    x_q,
    input  lsu_pkg::row_idx_t    y_q,
    input  lsu_pkg::row_idx_t    elem_q,
    input  lsu_pkg::row_idx_t    rows_q,
    input  lsu_pkg::ram_addr_t   addr_q,

    output logic                 done,

    // buffer write port
    output logic                 iram_we,
    output logic                 wram_we,
    output lsu_pkg::ram_addr_t   wr_addr,
    output lsu_pkg::row_word_t   wr_data
);
    import lsu_pkg::*;

    store_state_e state;

    // accumulator row for the next write
    row_idx_t  row_ptr;
    // rows written so far in this store
    row_idx_t  row_num;
    ram_addr_t addr_ptr;

    logic      wr_fire;
    logic      last_row;
    row_word_t row_raw;
    row_word_t row_shift;

    // one row per cycle while the accumulator has data
    assign wr_fire = (state == st_run) && mxu_data_rdy;
    assign last_row = (row_num == rows_q);
    assign done = wr_fire && last_row;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            row_ptr <= '0;
            row_num <= '0;
            addr_ptr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        row_ptr <= y_q;
                        row_num <= '0;
                        addr_ptr <= addr_q;
                    end
                end
                st_run: begin
                    if (wr_fire) begin
                        // rows wrap around the accumulator
                        if (row_ptr == row_idx_t'(ROWS - 1)) begin
                            row_ptr <= '0;
                        end else begin
                            row_ptr <= row_ptr + 1'b1;
                        end
                        row_num <= row_num + 1'b1;
                        // address wraps at the top of the buffer
                        addr_ptr <= addr_ptr + 1'b1;
                        if (last_row) begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // row select
    assign row_raw = mxu_rows[row_ptr];

    // start_x moves down to byte 0, bytes past the row end come in as zero
    assign row_shift = row_raw >> {x_q, 3'b000};

    // keep elem_q+1 bytes, clear the rest
    always_comb begin
        wr_data = '0;
        for (int i = 0; i < ROW_BYTES; i++) begin
            if (i <= int'(elem_q)) begin
                wr_data[8*i +: 8] = row_shift[8*i +: 8];
            end
        end
    end

    assign wr_addr = addr_ptr;

    // route the write to the buffer named by the opcode
    assign iram_we = wr_fire && (op_q == op_st_iram);
    assign wram_we = wr_fire && (op_q == op_st_wram);

endmodule

/* design/lsu_instr_ctrl.sv */
module lsu_instr_ctrl (
    input  logic                 clk,
    input  logic                 reset,

    // instruction from the decoder
    input  logic                 instr_vld,
    input  lsu_pkg::lsu_op_e     instr_op,
    input  lsu_pkg::row_idx_t    start_x,
    input  lsu_pkg::row_idx_t    start_y,
    input  lsu_pkg::row_idx_t    elem_cnt,
    input  lsu_pkg::row_idx_t    row_cnt,
    input  lsu_pkg::ram_addr_t   st_addr,

    // end of store from the engine
    input  logic                 done,

    output logic                 instr_rdy,
    output logic                 start,

    // payload held for the whole store
    output lsu_pkg::lsu_op_e     op_q,
    output lsu_pkg::row_idx_t    x_q,
    output lsu_pkg::row_idx_t    y_q,
    output lsu_pkg::row_idx_t    elem_q,
    output lsu_pkg::row_idx_t    rows_q,
    output lsu_pkg::ram_addr_t   addr_q
);

    logic busy;
    logic accept;

    // done reopens the port in the cycle of the last write
    assign instr_rdy = ~busy | done;
    assign accept = instr_vld & instr_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            start <= 1'b0;
        end else begin
            // a new accept on the done edge keeps busy set
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            start <= accept;
        end
    end

    // capture the instruction fields on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= instr_op;
            x_q <= start_x;
            y_q <= start_y;
            elem_q <= elem_cnt;
            rows_q <= row_cnt;
            addr_q <= st_addr;
        end
    end

endmodule

/* design/scratch_ram.sv */
module scratch_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 128
) (
    input  logic                     clk,

    // write side, from the store engine
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,

    // read side, toward the matrix unit
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old word on a same-address write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* common/lsu_pkg.sv */
package lsu_pkg;

    // accumulator and scratch buffer geometry
    localparam int acc_rows = 16;
    localparam int row_bytes = 16;
    localparam int ram_depth = 256;

    // row or column index inside the accumulator
    typedef logic [3:0] row_idx_t;

    // scratch buffer word address
    typedef logic [7:0] ram_addr_t;

    // one int8 accumulator row, also one buffer word
    typedef logic [8*row_bytes-1:0] row_word_t;

    // whole accumulator, row 0 in the low slice
    typedef logic [acc_rows-1:0][8*row_bytes-1:0] acc_rows_t;

    // store target
    typedef enum logic {
        op_st_iram = 1'b0,
        op_st_wram = 1'b1
    } lsu_op_e;

    // store engine states
    typedef enum logic {
        st_idle = 1'b0,
        st_run  = 1'b1
    } store_state_e;

endpackage
